// ==== build.f ====
+incdir+logic
logic/axil_pkg.sv
logic/board_pkg.sv
logic/axil_reg_slave.sv
logic/key_debounce.sv
logic/reset_pulse_gen.sv
logic/led_driver.sv
logic/db25_pin_map.sv
logic/board_io_top.sv
dv/board_io_tb.sv

// ==== dv/board_io_tb.sv ====
// directed tests only; one clock domain, stops at the first mismatch, every wait is bounded
`default_nettype none

`include "board_consts.svh"

module board_io_tb import axil_pkg::*, board_pkg::*; ();
	localparam int TIMEOUT = 200;           // cycles per wait loop

	logic        fpga_clk_50;
	logic        rst_n;
	axil_req_t   axil_req;
	axil_resp_t  axil_resp;
	key_t        key;                       // active low
	sw_t         sw;
	led_t        led;
	gpio_t       gpio;
	hps_reset_t  hps_reset;
	int          cycles;                    // edges since start
	logic [31:0] rng_state;

	board_io_top board_io_top_i (
		.fpga_clk_50 (fpga_clk_50),
		.rst_n       (rst_n),
		.axil_req    (axil_req),
		.axil_resp   (axil_resp),
		.key         (key),
		.sw          (sw),
		.led         (led),
		.gpio        (gpio),
		.hps_reset   (hps_reset)
	);

	initial begin
		fpga_clk_50 = 1'b0;
		forever #50 fpga_clk_50 = ~fpga_clk_50;
	end

	// ==========================================================================
	// helpers
	// ==========================================================================
	task automatic tick();
		@(posedge fpga_clk_50);
		#10;                                // drive and sample point
		cycles++;
	endtask

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic give_up(input string what);
		$display("ERROR t=%0t %s", $time, what);
		stop_run();
	endtask

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// header pins as the adaptor wiring defines them
	function automatic gpio_t expected_pins(input io_bits_t io, input adaptor_cfg_t cfg);
		gpio_t p;
		int    base;
		int    pin;
		p = '0;
		if (cfg.mode == STRAIGHT) begin
			p = {cfg.leds, io};
		end else begin
			for (int h = 0; h < 2; h++) begin
				base = 18 * h;
				for (int i = 0; i < 17; i++) begin
					pin = (i % 2 == 0) ? base + 16 - i : base + 18 - i;
					p[pin] = io[17*h + i];
				end
				p[base + 1] = cfg.leds[h];  // connector led
			end
		end
		return p;
	endfunction

	// compare tasks, one per result type
	task automatic check_led(input string name, input led_t got, input led_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
			stop_run();
		end
	endtask

	task automatic check_reset(input string name, input hps_reset_t got, input hps_reset_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// ==========================================================================
	// bus tasks
	// ==========================================================================
	// returns one cycle after the accept edge, when the pins already show the write
	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output axil_resp_e bresp);
		int n;
		n = 0;
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.wstrb   = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b1;
		while (!axil_resp.awready) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("write was never accepted");
		end
		check_word("wready", {31'b0, axil_resp.wready}, 32'h1);   // raised with awready
		tick();                             // accept edge
		check_word("ready after accept", {30'b0, axil_resp.awready, axil_resp.wready}, 32'h0);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		n = 0;
		while (!axil_resp.bvalid) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("write response never came");
		end
		bresp = axil_resp.bresp;
		tick();                             // response taken
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
			output axil_resp_e rresp);
		int n;
		n = 0;
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b1;
		while (!axil_resp.arready) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("read was never accepted");
		end
		tick();
		axil_req.arvalid = 1'b0;
		n = 0;
		while (!axil_resp.rvalid) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("read data never came");
		end
		data  = axil_resp.rdata;
		rresp = axil_resp.rresp;
		tick();
		axil_req.rready = 1'b0;
	endtask

	// ==========================================================================
	// tests
	// ==========================================================================
	task automatic check_after_reset();
		check_led("led", led, '0);
		check_gpio("gpio", gpio, '0);
		check_reset("hps_reset", hps_reset, '0);
		check_word("ready/valid", {27'b0, axil_resp.awready, axil_resp.wready,
			axil_resp.bvalid, axil_resp.arready, axil_resp.rvalid}, 32'h0);
	endtask

	task automatic test_register_round_trip();
		logic [31:0] d;
		logic [31:0] lo;
		logic [31:0] rd;
		axil_resp_e  r;
		d = xorshift32();
		axil_write(LED_REG, d, 4'hF, r);
		check_resp("bresp LED_REG", r, OKAY);
		axil_read(LED_REG, rd, r);
		check_resp("rresp LED_REG", r, OKAY);
		check_word("rdata LED_REG", rd, d & 32'h0000_00FE);   // bit 0 not stored
		lo = xorshift32();
		axil_write(IO_LO, lo, 4'hF, r);
		axil_read(IO_LO, rd, r);
		check_word("rdata IO_LO", rd, lo);
		d = xorshift32();
		axil_write(IO_HI, d, 4'hF, r);
		axil_read(IO_HI, rd, r);
		check_word("rdata IO_HI", rd, d & 32'h3);
		d = xorshift32();
		axil_write(ADAPTOR, d, 4'hF, r);
		axil_read(ADAPTOR, rd, r);
		check_word("rdata ADAPTOR", rd, d & 32'h7);
		// byte lanes 0 and 2 only
		d = xorshift32();
		axil_write(IO_LO, d, 4'b0101, r);
		lo = (lo & 32'hFF00_FF00) | (d & 32'h00FF_00FF);
		axil_read(IO_LO, rd, r);
		check_word("rdata IO_LO strobed", rd, lo);
		axil_read(RESET_REQ, rd, r);
		check_resp("rresp RESET_REQ", r, OKAY);
		check_word("rdata RESET_REQ", rd, 32'h0);
		// off the map
		axil_read(32'h18, rd, r);
		check_resp("rresp unknown", r, SLVERR);
		check_word("rdata unknown", rd, 32'h0);
		axil_write(32'h100C, xorshift32(), 4'hF, r);         // IO_LO offset in the low bits
		check_resp("bresp unknown", r, SLVERR);
		axil_read(IO_LO, rd, r);
		check_word("IO_LO after stray write", rd, lo);
	endtask

	task automatic test_pin_mapping();
		io_bits_t     io;
		adaptor_cfg_t cfg;
		logic [31:0]  d;
		axil_resp_e   r;
		axil_write(IO_HI, 32'h0, 4'hF, r);
		axil_write(IO_LO, 32'h0, 4'hF, r);
		io = '0;
		for (int m = 0; m < 2; m++) begin
			for (int k = 0; k < 3; k++) begin
				d = xorshift32();
				cfg.mode = (m == 0) ? STRAIGHT : DB25;
				cfg.leds = d[1:0];
				axil_write(ADAPTOR, {29'b0, cfg}, 4'hF, r);
				check_gpio("gpio after ADAPTOR", gpio, expected_pins(io, cfg));
				io[31:0] = xorshift32();
				axil_write(IO_LO, io[31:0], 4'hF, r);
				check_gpio("gpio after IO_LO", gpio, expected_pins(io, cfg));
				d = xorshift32();
				io[33:32] = d[1:0];
				axil_write(IO_HI, d, 4'hF, r);
				check_gpio("gpio after IO_HI", gpio, expected_pins(io, cfg));
			end
		end
		d = xorshift32();
		axil_write(LED_REG, d, 4'hF, r);
		check_led("led[7:1]", led & 8'hFE, d[7:0] & 8'hFE);   // led[0] is heartbeat
	endtask

	// waits for the masked hps_reset bits to drop, length counted from start
	task automatic measure_pulse(input hps_reset_t mask, input int start, output int len);
		int n;
		n = 0;
		while ((hps_reset & mask) != '0) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("reset pulse never ended");
		end
		len = cycles - start;
	endtask

	task automatic test_reset_pulses();
		hps_reset_t  want;
		int          lens [3];
		int          start;
		int          len;
		logic [31:0] rd;
		axil_resp_e  r;
		lens[0] = `COLD_PULSE_LEN;
		lens[1] = `WARM_PULSE_LEN;
		lens[2] = `DEBUG_PULSE_LEN;
		for (int k = 0; k < 3; k++) begin
			want = hps_reset_t'(3'b001 << k);
			axil_write(RESET_REQ, 32'(1) << k, 4'hF, r);
			check_resp("bresp RESET_REQ", r, OKAY);
			check_reset("hps_reset start", hps_reset, want);
			start = cycles;
			if (k == 2) begin                       // long enough to poll STATUS
				axil_read(STATUS, rd, r);
				check_word("STATUS busy", rd & 32'h1C0, 32'h100);
			end
			measure_pulse(want, start, len);
			check_word("pulse cycles", 32'(len), 32'(lens[k]));
			check_reset("hps_reset end", hps_reset, '0);
		end
		// second cold request lands mid pulse
		want = '{debug: 1'b0, warm: 1'b0, cold: 1'b1};
		axil_write(RESET_REQ, 32'h1, 4'hF, r);
		start = cycles;
		axil_write(RESET_REQ, 32'h1, 4'hF, r);
		check_reset("cold still high", hps_reset, want);
		measure_pulse(want, start, len);
		check_word("cold pulse with retrigger", 32'(len), 32'(`COLD_PULSE_LEN));
		repeat (10) begin
			tick();
			check_reset("no extra pulse", hps_reset, '0);
		end
		axil_read(STATUS, rd, r);
		check_word("STATUS idle", rd & 32'h1C0, 32'h0);
	endtask

	// polls STATUS until key bit k reads as level
	task automatic poll_key(input int k, input logic level);
		logic [31:0] rd;
		axil_resp_e  r;
		int          n;
		n = 0;
		axil_read(STATUS, rd, r);
		while (rd[k] !== level) begin
			n++;
			if (n > 20) give_up("debounced key never changed");
			axil_read(STATUS, rd, r);
		end
	endtask

	task automatic test_debounce();
		logic [31:0] rd;
		logic [31:0] d;
		axil_resp_e  r;
		int          start;
		key = 2'b10;                            // key 0 glitch
		repeat (5) tick();
		key = 2'b11;
		repeat (6) begin
			axil_read(STATUS, rd, r);
			check_word("STATUS keys after glitch", rd & 32'h3, 32'h0);
		end
		key = 2'b01;                            // hold key 1
		start = cycles;
		poll_key(1, 1'b1);
		if (cycles - start < `DEBOUNCE_CYCLES) give_up("key press seen before debounce time");
		axil_read(STATUS, rd, r);
		check_word("STATUS keys pressed", rd & 32'h3, 32'h2);
		key = 2'b11;
		start = cycles;
		poll_key(1, 1'b0);
		if (cycles - start < `DEBOUNCE_CYCLES) give_up("key release seen before debounce time");
		repeat (2) begin
			d = xorshift32();
			sw = d[3:0];
			tick();
			axil_read(STATUS, rd, r);
			check_word("STATUS switches", (rd >> 2) & 32'hF, {28'b0, d[3:0]});
		end
	endtask

	task automatic test_heartbeat();
		logic last;
		int   t0;
		int   n;
		last = led[0];
		n = 0;
		while (led[0] == last) begin            // align to a toggle
			tick();
			n++;
			if (n > TIMEOUT) give_up("heartbeat never toggled");
		end
		repeat (2) begin
			last = led[0];
			t0 = cycles;
			n = 0;
			while (led[0] == last) begin
				tick();
				n++;
				if (n > TIMEOUT) give_up("heartbeat stopped");
			end
			check_word("heartbeat period", 32'(cycles - t0), 32'(`BLINK_CYCLES));
		end
	endtask

	task automatic test_back_pressure();
		logic [31:0] rd;
		axil_resp_e  r;
		int          n;
		axil_req.awaddr  = LED_REG;
		axil_req.wdata   = 32'h0000_00AA;
		axil_req.wstrb   = 4'hF;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b0;                // master stalls B
		n = 0;
		while (!axil_resp.awready) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("first write was never accepted");
		end
		tick();
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		check_word("bvalid after accept", {31'b0, axil_resp.bvalid}, 32'h1);
		repeat (5) begin
			tick();
			check_word("bvalid held", {31'b0, axil_resp.bvalid}, 32'h1);
		end
		// second write must wait for the pending response
		axil_req.wdata   = 32'h0000_0054;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		repeat (4) begin
			tick();
			check_word("awready blocked", {31'b0, axil_resp.awready}, 32'h0);
		end
		check_resp("bresp held", axil_resp.bresp, OKAY);
		axil_req.bready = 1'b1;
		tick();                                 // B handshake
		axil_req.bready = 1'b0;
		check_word("bvalid cleared", {31'b0, axil_resp.bvalid}, 32'h0);
		n = 0;
		while (!axil_resp.awready) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("second write was never accepted");
		end
		tick();
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		axil_req.bready  = 1'b1;
		n = 0;
		while (!axil_resp.bvalid) begin
			tick();
			n++;
			if (n > TIMEOUT) give_up("second write response never came");
		end
		tick();
		axil_req.bready = 1'b0;
		axil_read(LED_REG, rd, r);
		check_word("LED_REG after second write", rd, 32'h0000_0054);
	endtask

	// ==========================================================================
	// sequence
	// ==========================================================================
	initial begin
		rng_state = 32'd84;                     // xorshift seed
		cycles    = 0;
		rst_n     = 1'b0;
		axil_req  = '0;
		key       = '1;                         // released
		sw        = '0;
		repeat (3) tick();
		rst_n = 1'b1;
		check_after_reset();
		test_register_round_trip();
		test_pin_mapping();
		test_reset_pulses();
		test_debounce();
		test_heartbeat();
		test_back_pressure();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/axil_pkg.sv ====
// 32-bit AXI4-Lite only; no prot signals, no burst or id fields
`default_nettype none

package axil_pkg;

	// response codes actually produced by the slave
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	// master to slave
	typedef struct packed {
		logic [31:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;       // one bit per byte lane
		logic        wvalid;
		logic        bready;
		logic [31:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		axil_resp_e  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		axil_resp_e  rresp;
		logic        rvalid;
	} axil_resp_t;

endpackage

`default_nettype wire

// ==== logic/axil_reg_slave.sv ====
// one write and one read outstanding at most; the full 32-bit address is decoded, anything off the map gets SLVERR
`default_nettype none

`include "board_consts.svh"

module axil_reg_slave import axil_pkg::*, board_pkg::*; (
	input  logic         fpga_clk_50,
	input  logic         rst_n,
	input  axil_req_t    req,
	output axil_resp_t   resp,
	input  key_t         keys,          // debounced, 1 = pressed
	input  sw_t          sw,
	input  hps_reset_t   reset_busy,
	output led_t         led_pattern,
	output io_bits_t     io_bits,
	output adaptor_cfg_t adaptor,
	output hps_reset_t   reset_strobe
);
	logic        aw_rdy_q;              // drives awready and wready together
	logic        bvalid_q;
	axil_resp_e  bresp_q;
	logic        ar_rdy_q;
	logic        rvalid_q;
	axil_resp_e  rresp_q;
	logic [31:0] rdata_q;
	logic        wr_fire;
	logic        rd_fire;
	logic [31:0] wmask;
	logic [32:0] wr_lookup;             // {hit, current word}
	logic [32:0] rd_lookup;
	logic [31:0] wr_merged;

	// current contents of a register, hit flag on top
	function automatic logic [32:0] lookup(input logic [31:0] addr);
		logic [32:0] hit_word;
		case (reg_addr_e'(addr))
			LED_REG:   hit_word = {1'b1, {(32-`LED_W){1'b0}}, led_pattern};
			RESET_REQ: hit_word = {1'b1, 32'b0};          // strobes only
			STATUS:    hit_word = {1'b1, {(29-`SW_W-`KEY_W){1'b0}}, reset_busy, sw, keys};
			IO_LO:     hit_word = {1'b1, io_bits[31:0]};
			IO_HI:     hit_word = {1'b1, {(64-`IO_W){1'b0}}, io_bits[`IO_W-1:32]};
			ADAPTOR:   hit_word = {1'b1, {(31-`ADAPTOR_LED_W){1'b0}}, adaptor};
			default:   hit_word = '0;
		endcase
		return hit_word;
	endfunction

	assign wr_fire = aw_rdy_q && req.awvalid && req.wvalid;
	assign rd_fire = ar_rdy_q && req.arvalid;

	// byte lane mask from wstrb
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			wmask[8*b +: 8] = {8{req.wstrb[b]}};
		end
	end

	assign wr_lookup = lookup(req.awaddr);
	assign rd_lookup = lookup(req.araddr);
	assign wr_merged = (wr_lookup[31:0] & ~wmask) | (req.wdata & wmask);

	// ==========================================================================
	// write channel and register file
	// ==========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			aw_rdy_q     <= 1'b0;
			bvalid_q     <= 1'b0;
			bresp_q      <= OKAY;
			led_pattern  <= '0;
			io_bits      <= '0;
			adaptor      <= '0;
			reset_strobe <= '0;
		end else begin
			// ready for one cycle, only while no response is pending
			aw_rdy_q     <= req.awvalid && req.wvalid && !bvalid_q && !aw_rdy_q;
			reset_strobe <= '0;                           // strobes are single cycle
			if (wr_fire) begin
				bvalid_q <= 1'b1;
				bresp_q  <= wr_lookup[32] ? OKAY : SLVERR;
				case (reg_addr_e'(req.awaddr))
					LED_REG:   led_pattern <= {wr_merged[`LED_W-1:1], 1'b0};  // bit 0 is heartbeat
					RESET_REQ: reset_strobe <= hps_reset_t'(req.wdata[2:0] & {3{req.wstrb[0]}});
					IO_LO:     io_bits[31:0] <= wr_merged;
					IO_HI:     io_bits[`IO_W-1:32] <= wr_merged[`IO_W-33:0];
					ADAPTOR:   adaptor <= adaptor_cfg_t'(wr_merged[`ADAPTOR_LED_W:0]);
					default:   ;                              // STATUS is read only, others ignored
				endcase
			end else if (bvalid_q && req.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// ==========================================================================
	// read channel
	// ==========================================================================
	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			ar_rdy_q <= 1'b0;
			rvalid_q <= 1'b0;
			rresp_q  <= OKAY;
		end else begin
			ar_rdy_q <= req.arvalid && !rvalid_q && !ar_rdy_q;
			if (rd_fire) begin
				rvalid_q <= 1'b1;
				rresp_q  <= rd_lookup[32] ? OKAY : SLVERR;
			end else if (rvalid_q && req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// read data, held until rready
	always_ff @(posedge fpga_clk_50) begin
		if (rd_fire) begin
			rdata_q <= rd_lookup[31:0];               // 0 for unknown offsets
		end
	end

	assign resp = '{
		awready: aw_rdy_q,
		wready:  aw_rdy_q,
		bresp:   bresp_q,
		bvalid:  bvalid_q,
		arready: ar_rdy_q,
		rdata:   rdata_q,
		rresp:   rresp_q,
		rvalid:  rvalid_q
	};

	// responses hold under back-pressure from the master
	assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		resp.bvalid && !req.bready |=> resp.bvalid);
	assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		resp.rvalid && !req.rready |=> resp.rvalid && $stable(resp.rdata));
	// two writes can never be accepted on adjacent edges
	assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		reset_strobe != '0 |=> reset_strobe == '0);

endmodule

`default_nettype wire

// ==== logic/board_consts.svh ====
// timing values are scaled for simulation; use 50000 and 25000000 for DEBOUNCE_CYCLES and BLINK_CYCLES on the board
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// ==========================================================================
// timing
// ==========================================================================
`define DEBOUNCE_CYCLES 16        // stable cycles before a key flips
`define DEBOUNCE_CNT_W  5         // holds 0..DEBOUNCE_CYCLES
`define BLINK_CYCLES    20        // cycles between heartbeat toggles

// hps reset request stretch, in clock cycles
`define COLD_PULSE_LEN  6
`define WARM_PULSE_LEN  2
`define DEBUG_PULSE_LEN 32

// ==========================================================================
// board widths
// ==========================================================================
`define KEY_W         2
`define SW_W          4
`define LED_W         8
`define IO_W          34          // io bits on the single header
`define GPIO_W        36          // header pins
`define ADAPTOR_LED_W 2           // one led per db25 connector

`endif

// ==== logic/board_io_top.sv ====
// single 50 MHz domain with a synchronous reset; the host bus is AXI4-Lite and the header is output only
`default_nettype none

`include "board_consts.svh"

module board_io_top import axil_pkg::*, board_pkg::*; (
	input  logic       fpga_clk_50,
	input  logic       rst_n,
	input  axil_req_t  axil_req,
	output axil_resp_t axil_resp,
	input  key_t       key,              // active low buttons
	input  sw_t        sw,
	output led_t       led,
	output gpio_t      gpio,
	output hps_reset_t hps_reset         // active high request pulses
);
	key_t         keys_pressed;
	led_t         led_pattern;
	io_bits_t     io_bits;
	adaptor_cfg_t adaptor;
	hps_reset_t   reset_strobe;
	logic         cold_pulse;
	logic         warm_pulse;
	logic         debug_pulse;

	// ==========================================================================
	// host registers and inputs
	// ==========================================================================
	axil_reg_slave axil_reg_slave_i (
		.fpga_clk_50  (fpga_clk_50),
		.rst_n        (rst_n),
		.req          (axil_req),
		.resp         (axil_resp),
		.keys         (keys_pressed),
		.sw           (sw),
		.reset_busy   (hps_reset),       // pulses double as busy flags
		.led_pattern  (led_pattern),
		.io_bits      (io_bits),
		.adaptor      (adaptor),
		.reset_strobe (reset_strobe)
	);

	key_debounce key_debounce_i (
		.fpga_clk_50 (fpga_clk_50),
		.rst_n       (rst_n),
		.key_n       (key),
		.pressed     (keys_pressed)
	);

	// hps reset stretchers
	reset_pulse_gen #(.PULSE_LEN(`COLD_PULSE_LEN)) cold_pulse_i (
		.fpga_clk_50 (fpga_clk_50),
		.rst_n       (rst_n),
		.request     (reset_strobe.cold),
		.pulse       (cold_pulse)
	);

	reset_pulse_gen #(.PULSE_LEN(`WARM_PULSE_LEN)) warm_pulse_i (
		.fpga_clk_50 (fpga_clk_50),
		.rst_n       (rst_n),
		.request     (reset_strobe.warm),
		.pulse       (warm_pulse)
	);

	reset_pulse_gen #(.PULSE_LEN(`DEBUG_PULSE_LEN)) debug_pulse_i (
		.fpga_clk_50 (fpga_clk_50),
		.rst_n       (rst_n),
		.request     (reset_strobe.debug),
		.pulse       (debug_pulse)
	);

	assign hps_reset = '{debug: debug_pulse, warm: warm_pulse, cold: cold_pulse};

	// ==========================================================================
	// outputs
	// ==========================================================================
	led_driver led_driver_i (
		.fpga_clk_50 (fpga_clk_50),
		.rst_n       (rst_n),
		.led_pattern (led_pattern),
		.led         (led)
	);

	db25_pin_map db25_pin_map_i (
		.fpga_clk_50 (fpga_clk_50),
		.rst_n       (rst_n),
		.io_bits     (io_bits),
		.adaptor     (adaptor),
		.gpio        (gpio)
	);

endmodule

`default_nettype wire

// ==== logic/board_pkg.sv ====
// widths come from board_consts.svh; the register map assumes word aligned byte offsets
`default_nettype none

`include "board_consts.svh"

package board_pkg;

	// pin level vectors
	typedef logic [`KEY_W-1:0]  key_t;
	typedef logic [`SW_W-1:0]   sw_t;
	typedef logic [`LED_W-1:0]  led_t;
	typedef logic [`IO_W-1:0]   io_bits_t;
	typedef logic [`GPIO_W-1:0] gpio_t;

	// cold lands on bit 0, same order as RESET_REQ and STATUS
	typedef struct packed {
		logic debug;
		logic warm;
		logic cold;
	} hps_reset_t;

	typedef enum logic {
		STRAIGHT = 1'b0,          // io bits go to the header as is
		DB25     = 1'b1           // pin order of the db25 adaptor
	} adaptor_mode_e;

	// packs as {leds, mode}, matching ADAPTOR bits 2:0
	typedef struct packed {
		logic [`ADAPTOR_LED_W-1:0] leds;
		adaptor_mode_e             mode;
	} adaptor_cfg_t;

	// host register byte offsets
	typedef enum logic [31:0] {
		LED_REG   = 32'h00,
		RESET_REQ = 32'h04,
		STATUS    = 32'h08,
		IO_LO     = 32'h0C,
		IO_HI     = 32'h10,
		ADAPTOR   = 32'h14
	} reg_addr_e;

endpackage

`default_nettype wire

// ==== logic/db25_pin_map.sv ====
// output only; the header is modelled without tristate, mode changes take effect one cycle later
`default_nettype none

`include "board_consts.svh"

module db25_pin_map import board_pkg::*; (
	input  logic         fpga_clk_50,
	input  logic         rst_n,
	input  io_bits_t     io_bits,
	input  adaptor_cfg_t adaptor,
	output gpio_t        gpio
);
	localparam int HALF_IO   = `IO_W / 2;       // io bits per db25 connector
	localparam int HALF_PINS = `GPIO_W / 2;     // header pins per connector

	gpio_t pin_map;

	// ==========================================================================
	// pin order
	// ==========================================================================
	always_comb begin
		pin_map = '0;
		if (adaptor.mode == STRAIGHT) begin
			pin_map = {adaptor.leds, io_bits};      // leds above the io bits
		end else begin
			for (int h = 0; h < 2; h++) begin
				for (int i = 0; i < HALF_IO; i++) begin
					// adaptor pins alternate between the two header rows
					if (i % 2 == 0) begin
						pin_map[h*HALF_PINS + 16 - i] = io_bits[h*HALF_IO + i];
					end else begin
						pin_map[h*HALF_PINS + 18 - i] = io_bits[h*HALF_IO + i];
					end
				end
				pin_map[h*HALF_PINS + 1] = adaptor.leds[h];   // connector status led
			end
		end
	end

	// registered onto the pins
	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			gpio <= '0;
		end else begin
			gpio <= pin_map;
		end
	end

endmodule

`default_nettype wire

// ==== logic/key_debounce.sv ====
// keys are active low and asynchronous; a level must hold DEBOUNCE_CYCLES cycles after the synchronizer
`default_nettype none

`include "board_consts.svh"

module key_debounce import board_pkg::*; (
	input  logic fpga_clk_50,
	input  logic rst_n,
	input  key_t key_n,                 // raw buttons, 0 = pressed
	output key_t pressed                // debounced, 1 = pressed
);
	localparam int unsigned      CNT_W    = `DEBOUNCE_CNT_W;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

	key_t                         meta_q;
	key_t                         sync_q;
	logic [`KEY_W-1:0][CNT_W-1:0] cnt_q;

	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			meta_q  <= '1;                  // released
			sync_q  <= '1;
			cnt_q   <= '0;
			pressed <= '0;
		end else begin
			meta_q <= key_n;
			sync_q <= meta_q;
			for (int i = 0; i < `KEY_W; i++) begin
				// sync level != pressed means the key agrees with the output
				if (sync_q[i] != pressed[i]) begin
					cnt_q[i] <= '0;
				end else if (cnt_q[i] == CNT_LAST) begin
					cnt_q[i]   <= '0;
					pressed[i] <= ~sync_q[i];   // held long enough
				end else begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	for (genvar g = 0; g < `KEY_W; g++) begin : g_chk
		// a debounced bit never moves before its stability count runs out
		assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
			$changed(pressed[g]) |-> $past(cnt_q[g]) == CNT_LAST);
	end

endmodule

`default_nettype wire

// ==== logic/led_driver.sv ====
// led[0] is owned by the heartbeat; pattern bit 0 from the host is not shown
`default_nettype none

`include "board_consts.svh"

module led_driver import board_pkg::*; (
	input  logic fpga_clk_50,
	input  logic rst_n,
	input  led_t led_pattern,
	output led_t led
);
	localparam int unsigned     HB_W    = $clog2(`BLINK_CYCLES);
	localparam logic [HB_W-1:0] HB_LAST = HB_W'(`BLINK_CYCLES - 1);

	logic [HB_W-1:0] hb_cnt_q;

	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			hb_cnt_q <= '0;
			led      <= '0;
		end else begin
			led[`LED_W-1:1] <= led_pattern[`LED_W-1:1];   // output register
			if (hb_cnt_q == HB_LAST) begin
				hb_cnt_q <= '0;
				led[0]   <= ~led[0];                      // heartbeat toggle
			end else begin
				hb_cnt_q <= hb_cnt_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/reset_pulse_gen.sv ====
// rising edges of request start a PULSE_LEN cycle pulse; edges during a pulse are dropped, not queued
`default_nettype none

module reset_pulse_gen #(
	parameter int unsigned PULSE_LEN = 4
) (
	input  logic fpga_clk_50,
	input  logic rst_n,
	input  logic request,
	output logic pulse
);
	localparam int unsigned      CNT_W    = $clog2(PULSE_LEN + 1);
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PULSE_LEN);

	logic             req_q;            // previous request, for edge detect
	logic [CNT_W-1:0] cnt_q;            // remaining pulse cycles
	logic             rise;

	assign rise = request && !req_q;

	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			req_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			req_q <= request;
			if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;      // busy, new edges ignored
			end else if (rise) begin
				cnt_q <= CNT_LOAD;
			end
		end
	end

	assign pulse = (cnt_q != '0);

	// stretched pulse ends exactly PULSE_LEN cycles after it starts
	assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		$rose(pulse) |-> ##PULSE_LEN !pulse);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator and run the board_io_tb regression
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module board_io_tb -o board_io_sim \
	&& ./obj_dir/board_io_sim | tee /dev/stderr | grep -q "Regression passed" \
	&& { echo "run.sh: simulation ok"; exit 0; } \
	|| { echo "run.sh: simulation did not pass"; exit 1; }
